// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  cpu_isa_pkg::opcode_e opcode,
  input  cpu_isa_pkg::word_t   a,
  input  cpu_isa_pkg::word_t   b,
  input  cpu_isa_pkg::flags_t  flags_in,
  output cpu_isa_pkg::word_t   result,
  output cpu_isa_pkg::flags_t  flags_out
);
  import cpu_isa_pkg::*;

  word_t       add_x;
  word_t       add_y;
  logic        add_cin;
  logic        is_arith;
  logic [32:0] sum;
  word_t       logic_res;
  logic        overflow;

  //////////////////////////////////////////////////////////////////////
  // adder operand select

  // subtraction is x + ~y + 1, reverse forms swap the inputs
  always_comb begin
    add_x    = a;
    add_y    = b;
    add_cin  = 1'b0;
    is_arith = 1'b1;
    case (opcode)
      op_sub, op_cmp: begin
        add_y   = ~b;
        add_cin = 1'b1;
      end
      op_rsb: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = 1'b1;
      end
      op_add, op_cmn: begin
        add_cin = 1'b0;
      end
      op_adc: add_cin = flags_in.c;
      op_sbc: begin
        add_y   = ~b;
        add_cin = flags_in.c;
      end
      op_rsc: begin
        add_x   = b;
        add_y   = ~a;
        add_cin = flags_in.c;
      end
      default: is_arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};

  // operands agree in sign but the sum does not
  assign overflow = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);

  //////////////////////////////////////////////////////////////////////
  // logical ops

  always_comb begin
    case (opcode)
      op_and, op_tst: logic_res = a & b;
      op_eor, op_teq: logic_res = a ^ b;
      op_orr:         logic_res = a | b;
      op_mov:         logic_res = b;
      op_bic:         logic_res = a & ~b;
      op_mvn:         logic_res = ~b;
      default:        logic_res = '0;
    endcase
  end

  assign result = is_arith ? sum[31:0] : logic_res;

  // logical ops carry C and V through
  assign flags_out.n = result[31];
  assign flags_out.z = (result == '0);
  assign flags_out.c = is_arith ? sum[32] : flags_in.c;
  assign flags_out.v = is_arith ? overflow : flags_in.v;

endmodule

// ==== rtl/code_mem.sv ====
`timescale 1ns/1ps

module code_mem (
  input  logic                     clk,
  input  logic                     load_we,
  input  cpu_core_pkg::code_addr_t load_addr,
  input  cpu_isa_pkg::word_t       load_data,
  input  cpu_core_pkg::code_addr_t fetch_addr,
  output cpu_isa_pkg::word_t       fetch_data
);
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  word_t mem [code_words];

  // program load port
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end
  end

  // fetch word shows up one cycle after the address
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

endmodule

// ==== rtl/cpu.sv ====
`timescale 1ns/1ps

module cpu (
  input  logic                     clk,
  input  logic                     nreset,
  input  logic                     load_we,
  input  cpu_core_pkg::code_addr_t load_addr,
  input  cpu_isa_pkg::word_t       load_data,
  output logic                     retire_valid,
  output cpu_core_pkg::retire_t    retire,
  output cpu_core_pkg::store_t     store
);
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  code_addr_t fetch_addr;
  word_t      fetch_data;
  word_t      inst;
  decoded_t   dec;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      pc;
  word_t      d1;
  word_t      d2;
  logic       rf_we;
  reg_idx_t   rf_ws;
  word_t      rf_wd;
  opcode_e    alu_op;
  word_t      alu_a;
  word_t      alu_b;
  flags_t     alu_flags_in;
  word_t      alu_result;
  flags_t     alu_flags;
  data_addr_t rd_addr;
  word_t      rd_data;

  code_mem u_code_mem (
    .clk(clk), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
    .fetch_addr(fetch_addr), .fetch_data(fetch_data)
  );

  inst_decoder u_inst_decoder (.inst(inst), .dec(dec));

  reg_file u_reg_file (
    .clk(clk), .rs1(rs1), .rs2(rs2), .pc(pc), .d1(d1), .d2(d2),
    .we(rf_we), .ws(rf_ws), .wd(rf_wd)
  );

  alu u_alu (
    .opcode(alu_op), .a(alu_a), .b(alu_b), .flags_in(alu_flags_in),
    .result(alu_result), .flags_out(alu_flags)
  );

  data_mem u_data_mem (.clk(clk), .st(store), .rd_addr(rd_addr), .rd_data(rd_data));

  cpu_control u_cpu_control (
    .clk(clk), .nreset(nreset),
    .fetch_addr(fetch_addr), .fetch_data(fetch_data),
    .inst(inst), .dec(dec),
    .rs1(rs1), .rs2(rs2), .pc(pc), .d1(d1), .d2(d2),
    .rf_we(rf_we), .rf_ws(rf_ws), .rf_wd(rf_wd),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_flags_in(alu_flags_in),
    .alu_result(alu_result), .alu_flags(alu_flags),
    .st(store), .rd_addr(rd_addr), .rd_data(rd_data),
    .retire_valid(retire_valid), .retire(retire)
  );

endmodule

// ==== rtl/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
  input  logic                     clk,
  input  logic                     nreset,
  output cpu_core_pkg::code_addr_t fetch_addr,
  input  cpu_isa_pkg::word_t       fetch_data,
  output cpu_isa_pkg::word_t       inst,
  input  cpu_core_pkg::decoded_t   dec,
  output cpu_isa_pkg::reg_idx_t    rs1,
  output cpu_isa_pkg::reg_idx_t    rs2,
  output cpu_isa_pkg::word_t       pc,
  input  cpu_isa_pkg::word_t       d1,
  input  cpu_isa_pkg::word_t       d2,
  output logic                     rf_we,
  output cpu_isa_pkg::reg_idx_t    rf_ws,
  output cpu_isa_pkg::word_t       rf_wd,
  output cpu_isa_pkg::opcode_e     alu_op,
  output cpu_isa_pkg::word_t       alu_a,
  output cpu_isa_pkg::word_t       alu_b,
  output cpu_isa_pkg::flags_t      alu_flags_in,
  input  cpu_isa_pkg::word_t       alu_result,
  input  cpu_isa_pkg::flags_t      alu_flags,
  output cpu_core_pkg::store_t     st,
  output cpu_core_pkg::data_addr_t rd_addr,
  input  cpu_isa_pkg::word_t       rd_data,
  output logic                     retire_valid,
  output cpu_core_pkg::retire_t    retire
);
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  stage_e stage;
  flags_t flags;
  word_t  inst_q;
  word_t  op_a;
  word_t  op_b;
  word_t  result_q;
  flags_t flags_q;
  word_t  addr_q;
  word_t  target_q;
  word_t  pc_plus4;
  logic   cond_ok;
  logic   is_compare;
  logic   writes;
  logic   flag_upd;
  flags_t flags_next;

  //////////////////////////////////////////////////////////////////////
  // stage sequence, pc and flags

  always_ff @(posedge clk) begin
    if (!nreset) begin
      stage <= stage_fetch;
      pc    <= '0;
      flags <= '0;
    end else begin
      case (stage)
        stage_fetch:   stage <= stage_decode;
        stage_decode:  stage <= stage_execute;
        stage_execute: stage <= stage_memory;
        stage_memory:  stage <= stage_writeback;
        default: begin
          stage <= stage_fetch;
          flags <= flags_next;
          // B, BL and BX all resolve to target_q
          pc    <= (cond_ok && dec.inst_class == class_br) ? target_q : pc_plus4;
        end
      endcase
    end
  end

  assign pc_plus4   = pc + 32'd4;
  assign fetch_addr = pc[$bits(code_addr_t)+1:2];

  // flags only move in writeback
  assign cond_ok = cond_passes(dec.cond, flags);

  //////////////////////////////////////////////////////////////////////
  // decode and execute latches

  // decoder sees the fresh fetch word while in decode
  assign inst = (stage == stage_decode) ? fetch_data : inst_q;
  assign rs1  = dec.rn;
  // store data comes from rd
  assign rs2  = (dec.inst_class == class_ls) ? dec.rd : dec.rm;

  always_ff @(posedge clk) begin
    if (stage == stage_decode) begin
      inst_q <= fetch_data;
      op_a   <= d1;
      op_b   <= dec.op2_is_imm ? word_t'(dec.imm) : d2;
    end
    if (stage == stage_execute) begin
      result_q <= alu_result;
      flags_q  <= alu_flags;
      addr_q   <= op_a + word_t'(dec.imm);
      target_q <= dec.is_bx ? {op_b[31:2], 2'b00} : pc + 32'd8 + dec.branch_offset;
    end
  end

  assign alu_op       = dec.opcode;
  assign alu_a        = op_a;
  assign alu_b        = op_b;
  assign alu_flags_in = flags;

  //////////////////////////////////////////////////////////////////////
  // memory stage

  assign st.we   = (stage == stage_memory) && cond_ok &&
                   dec.inst_class == class_ls && !dec.is_load;
  assign st.addr = addr_q[$bits(data_addr_t)+1:2];
  assign st.data = op_b;
  assign rd_addr = addr_q[$bits(data_addr_t)+1:2];

  //////////////////////////////////////////////////////////////////////
  // writeback and retire

  assign is_compare = dec.opcode inside {op_tst, op_teq, op_cmp, op_cmn};

  always_comb begin
    writes = 1'b0;
    rf_ws  = dec.rd;
    rf_wd  = result_q;
    if (cond_ok) begin
      case (dec.inst_class)
        class_dp: writes = !is_compare;
        class_ls: begin
          writes = dec.is_load;
          rf_wd  = rd_data;
        end
        default: begin
          // link holds the address after the branch
          writes = dec.is_link;
          rf_ws  = reg_lr;
          rf_wd  = pc_plus4;
        end
      endcase
    end
  end

  assign rf_we = (stage == stage_writeback) && writes;

  // compares always set flags
  assign flag_upd   = cond_ok && dec.inst_class == class_dp && (dec.set_flags || is_compare);
  assign flags_next = flag_upd ? flags_q : flags;

  assign retire_valid    = (stage == stage_writeback);
  assign retire.pc       = pc;
  assign retire.executed = cond_ok;
  assign retire.reg_we   = writes;
  assign retire.rd       = rf_ws;
  assign retire.value    = rf_wd;
  assign retire.flags    = flags_next;

endmodule

// ==== rtl/cpu_core_pkg.sv ====
package cpu_core_pkg;

  import cpu_isa_pkg::*;

  localparam int code_words = 64;
  localparam int data_words = 16;

  // word addresses, taken from the byte address above bit 1
  typedef logic [$clog2(code_words)-1:0] code_addr_t;
  typedef logic [$clog2(data_words)-1:0] data_addr_t;

  typedef enum logic [2:0] {
    stage_fetch,
    stage_decode,
    stage_execute,
    stage_memory,
    stage_writeback
  } stage_e;

  typedef struct packed {
    cond_e       cond;
    inst_class_e inst_class;
    opcode_e     opcode;
    logic        set_flags;
    logic        op2_is_imm;
    reg_idx_t    rn;
    reg_idx_t    rd;
    reg_idx_t    rm;
    logic [11:0] imm;
    logic        is_load;
    logic        is_link;
    logic        is_bx;
    word_t       branch_offset;
  } decoded_t;

  typedef struct packed {
    word_t    pc;
    logic     executed;
    logic     reg_we;
    reg_idx_t rd;
    word_t    value;
    flags_t   flags;
  } retire_t;

  typedef struct packed {
    logic       we;
    data_addr_t addr;
    word_t      data;
  } store_t;

endpackage

// ==== rtl/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0] reg_idx_t;

  localparam reg_idx_t reg_lr = 4'd14;
  localparam reg_idx_t reg_pc = 4'd15;

  // bits 27:4 of a BX instruction
  localparam logic [23:0] bx_pattern = 24'h12fff1;

  typedef enum logic [3:0] {
    op_and = 4'h0,
    op_eor = 4'h1,
    op_sub = 4'h2,
    op_rsb = 4'h3,
    op_add = 4'h4,
    op_adc = 4'h5,
    op_sbc = 4'h6,
    op_rsc = 4'h7,
    op_tst = 4'h8,
    op_teq = 4'h9,
    op_cmp = 4'ha,
    op_cmn = 4'hb,
    op_orr = 4'hc,
    op_mov = 4'hd,
    op_bic = 4'he,
    op_mvn = 4'hf
  } opcode_e;

  typedef enum logic [3:0] {
    cond_eq = 4'h0,
    cond_ne = 4'h1,
    cond_cs = 4'h2,
    cond_cc = 4'h3,
    cond_mi = 4'h4,
    cond_pl = 4'h5,
    cond_vs = 4'h6,
    cond_vc = 4'h7,
    cond_hi = 4'h8,
    cond_ls = 4'h9,
    cond_ge = 4'ha,
    cond_lt = 4'hb,
    cond_gt = 4'hc,
    cond_le = 4'hd,
    cond_al = 4'he
  } cond_e;

  typedef enum logic [1:0] {
    class_dp = 2'b00,
    class_ls = 2'b01,
    class_br = 2'b10
  } inst_class_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // condition field test, the 1111 encoding never passes
  function automatic logic cond_passes(cond_e cond, flags_t f);
    logic pass;
    case (cond)
      cond_eq: pass = f.z;
      cond_ne: pass = !f.z;
      cond_cs: pass = f.c;
      cond_cc: pass = !f.c;
      cond_mi: pass = f.n;
      cond_pl: pass = !f.n;
      cond_vs: pass = f.v;
      cond_vc: pass = !f.v;
      cond_hi: pass = f.c && !f.z;
      cond_ls: pass = !f.c || f.z;
      cond_ge: pass = (f.n == f.v);
      cond_lt: pass = (f.n != f.v);
      cond_gt: pass = !f.z && (f.n == f.v);
      cond_le: pass = f.z || (f.n != f.v);
      cond_al: pass = 1'b1;
      default: pass = 1'b0;
    endcase
    return pass;
  endfunction

endpackage

// ==== rtl/data_mem.sv ====
`timescale 1ns/1ps

module data_mem (
  input  logic                     clk,
  input  cpu_core_pkg::store_t     st,
  input  cpu_core_pkg::data_addr_t rd_addr,
  output cpu_isa_pkg::word_t       rd_data
);
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  word_t mem [data_words];

  always_ff @(posedge clk) begin
    if (st.we) begin
      mem[st.addr] <= st.data;
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  cpu_isa_pkg::word_t     inst,
  output cpu_core_pkg::decoded_t dec
);
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  always_comb begin
    dec = '0;

    // fields at fixed positions for every class
    dec.cond   = cond_e'(inst[31:28]);
    dec.opcode = opcode_e'(inst[24:21]);
    dec.rn     = inst[19:16];
    dec.rd     = inst[15:12];
    dec.rm     = inst[3:0];

    // 24-bit word offset, sign extended, in bytes
    dec.branch_offset = {{6{inst[23]}}, inst[23:0], 2'b00};

    if (inst[27:4] == bx_pattern) begin
      dec.inst_class = class_br;
      dec.is_bx      = 1'b1;
    end else begin
      case (inst[27:26])
        2'b01: begin
          // only the positive immediate offset form
          dec.inst_class = class_ls;
          dec.imm        = inst[11:0];
          dec.is_load    = inst[20];
        end
        2'b10: begin
          dec.inst_class = class_br;
          dec.is_link    = inst[24];
        end
        default: begin
          dec.inst_class = class_dp;
          dec.set_flags  = inst[20];
          dec.op2_is_imm = inst[25];
          // rotate field ignored
          dec.imm        = {4'b0000, inst[7:0]};
        end
      endcase
    end
  end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                 clk,
  input  cpu_isa_pkg::reg_idx_t rs1,
  input  cpu_isa_pkg::reg_idx_t rs2,
  input  cpu_isa_pkg::word_t    pc,
  output cpu_isa_pkg::word_t    d1,
  output cpu_isa_pkg::word_t    d2,
  input  logic                 we,
  input  cpu_isa_pkg::reg_idx_t ws,
  input  cpu_isa_pkg::word_t    wd
);
  import cpu_isa_pkg::*;

  // r0 to r14, r15 lives in the control block
  word_t regs [0:reg_lr];
  word_t pc_read;

  // pc reads two instructions ahead
  assign pc_read = pc + 32'd8;

  assign d1 = (rs1 == reg_pc) ? pc_read : regs[rs1];
  assign d2 = (rs2 == reg_pc) ? pc_read : regs[rs2];

  // writes to r15 are dropped
  always_ff @(posedge clk) begin
    if (we && ws != reg_pc) begin
      regs[ws] <= wd;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_cpu -Mdir obj_dir -o tb_cpu -f tb.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_cpu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
  exit 0
fi
exit 1

// ==== sim/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// instruction-set model state
word_t  prog [64];
word_t  m_regs [15];
word_t  m_mem [16];
flags_t m_flags;
word_t  m_pc;
int     seed = 53;

//////////////////////////////////////////////////////////////////////
// reference model

// r15 reads two instructions ahead
function automatic word_t read_reg(reg_idx_t r);
  return (r == 4'd15) ? m_pc + 32'd8 : m_regs[r];
endfunction

// codes come in pairs where the low bit inverts the test
function automatic logic cond_holds(logic [3:0] c, flags_t f);
  logic base;
  case (c[3:1])
    3'd0: base = f.z;
    3'd1: base = f.c;
    3'd2: base = f.n;
    3'd3: base = f.v;
    3'd4: base = f.c && !f.z;
    3'd5: base = (f.n == f.v);
    3'd6: base = !f.z && (f.n == f.v);
    default: base = 1'b1;
  endcase
  return base ^ c[0];
endfunction

// carry and overflow from exact unsigned and signed arithmetic
function automatic word_t alu_model(logic [3:0] op, word_t a, word_t b, flags_t fi,
                                    output flags_t fo);
  longint ua;
  longint ub;
  longint sa;
  longint sb;
  longint cin;
  longint u;
  longint s;
  logic   arith;
  logic   borrow_form;
  word_t  r;
  ua = longint'(a);
  ub = longint'(b);
  sa = longint'($signed(a));
  sb = longint'($signed(b));
  cin = longint'(fi.c);
  arith = 1'b1;
  borrow_form = 1'b1;
  u = 0;
  s = 0;
  case (op)
    4'h2, 4'ha: begin
      u = ua - ub;
      s = sa - sb;
    end
    4'h3: begin
      u = ub - ua;
      s = sb - sa;
    end
    4'h6: begin
      u = ua - ub - (1 - cin);
      s = sa - sb - (1 - cin);
    end
    4'h7: begin
      u = ub - ua - (1 - cin);
      s = sb - sa - (1 - cin);
    end
    4'h4, 4'hb: begin
      u = ua + ub;
      s = sa + sb;
      borrow_form = 1'b0;
    end
    4'h5: begin
      u = ua + ub + cin;
      s = sa + sb + cin;
      borrow_form = 1'b0;
    end
    default: arith = 1'b0;
  endcase
  case (op)
    4'h0, 4'h8: r = a & b;
    4'h1, 4'h9: r = a ^ b;
    4'hc: r = a | b;
    4'hd: r = b;
    4'he: r = a & ~b;
    4'hf: r = ~b;
    default: r = u[31:0];
  endcase
  fo.n = r[31];
  fo.z = (r == 32'd0);
  // no borrow means carry set
  fo.c = !arith ? fi.c : (borrow_form ? !u[63] : u[32]);
  fo.v = arith ? (s != longint'($signed(r))) : fi.v;
  return r;
endfunction

// runs the instruction at m_pc and reports what it should do
function automatic void model_step(output retire_t er, output store_t es);
  word_t      inst;
  word_t      b;
  word_t      r;
  word_t      addr;
  word_t      next_pc;
  logic [3:0] op;
  flags_t     f;
  flags_t     nf;
  inst = prog[m_pc[7:2]];
  op = inst[24:21];
  er = '0;
  es = '0;
  er.pc = m_pc;
  er.executed = cond_holds(inst[31:28], m_flags);
  nf = m_flags;
  next_pc = m_pc + 32'd4;
  if (er.executed) begin
    if (inst[27:4] == 24'h12fff1) begin
      next_pc = read_reg(inst[3:0]) & ~32'd3;
    end else if (inst[27:25] == 3'b101) begin
      if (inst[24]) begin
        er.reg_we = 1'b1;
        er.rd = 4'd14;
        er.value = m_pc + 32'd4;
      end
      next_pc = m_pc + 32'd8 + {{6{inst[23]}}, inst[23:0], 2'b00};
    end else if (inst[27:26] == 2'b01) begin
      addr = read_reg(inst[19:16]) + {20'd0, inst[11:0]};
      if (inst[20]) begin
        er.reg_we = 1'b1;
        er.rd = inst[15:12];
        er.value = m_mem[addr[5:2]];
      end else begin
        es.we = 1'b1;
        es.addr = addr[5:2];
        es.data = read_reg(inst[15:12]);
      end
    end else begin
      b = inst[25] ? {24'd0, inst[7:0]} : read_reg(inst[3:0]);
      r = alu_model(op, read_reg(inst[19:16]), b, m_flags, f);
      // tst, teq, cmp and cmn write no register but always set flags
      if (op[3:2] != 2'b10) begin
        er.reg_we = 1'b1;
        er.rd = inst[15:12];
        er.value = r;
      end
      if (inst[20] || op[3:2] == 2'b10) begin
        nf = f;
      end
    end
  end
  if (er.reg_we && er.rd != 4'd15) begin
    m_regs[er.rd] = er.value;
  end
  if (es.we) begin
    m_mem[es.addr] = es.data;
  end
  m_flags = nf;
  er.flags = nf;
  m_pc = next_pc;
endfunction

//////////////////////////////////////////////////////////////////////
// program generator

function automatic word_t enc_dp(logic [3:0] c, logic [3:0] op, logic imm, logic s,
                                 reg_idx_t rn, reg_idx_t rd, logic [7:0] op2);
  return {c, 2'b00, imm, op, s, rn, rd, 4'h0, op2};
endfunction

// positive immediate offset without writeback
function automatic word_t enc_mem(logic [3:0] c, logic load, reg_idx_t rn, reg_idx_t rd,
                                  logic [11:0] off);
  return {c, 4'b0101, 3'b100, load, rn, rd, off};
endfunction

function automatic word_t enc_br(logic [3:0] c, logic link, int words);
  return {c, 3'b101, link, 24'(words)};
endfunction

function automatic void build_program();
  word_t      r;
  word_t      r2;
  logic [3:0] c;
  reg_idx_t   rd;
  int         i;
  int         k;
  prog[0] = enc_dp(4'he, 4'hd, 1'b1, 1'b0, 4'd0, 4'd0, 8'h00);
  // clear all of data memory
  for (i = 1; i <= 16; i++) begin
    prog[i] = enc_mem(4'he, 1'b0, 4'd0, 4'd0, 12'((i - 1) * 4));
  end
  for (i = 17; i <= 30; i++) begin
    r = $random(seed);
    prog[i] = enc_dp(4'he, 4'hd, 1'b1, 1'b0, 4'd0, 4'(i - 16), r[7:0]);
  end
  // random body that never writes r13 or r14
  for (i = 31; i <= 59; i++) begin
    r = $random(seed);
    r2 = $random(seed);
    c = (r[7] || r[6:3] == 4'hf) ? 4'he : r[6:3];
    rd = 4'(r[19:16] % 13);
    case (r[2:0])
      3'd5: prog[i] = enc_mem(c, 1'b1, r[11:8], rd, r2[11:0]);
      3'd6: prog[i] = enc_mem(c, 1'b0, r[11:8], r[15:12], r2[11:0]);
      3'd7: begin
        k = 1 + int'(r2 % 3);
        if (i + k > 60) begin
          k = 60 - i;
        end
        prog[i] = enc_br(c, 1'b0, k - 2);
      end
      default: begin
        if (r[24]) begin
          prog[i] = enc_dp(c, r[23:20], 1'b1, r[25], r[11:8], rd, r2[7:0]);
        end else begin
          prog[i] = enc_dp(c, r[23:20], 1'b0, r[25], r[11:8], rd, {4'h0, r[15:12]});
        end
      end
    endcase
  end
  prog[60] = enc_br(4'he, 1'b1, 0);
  prog[61] = enc_br(4'he, 1'b0, -2);
  prog[62] = enc_dp(4'he, 4'h4, 1'b1, 1'b1, 4'd1, 4'd2, 8'h11);
  prog[63] = {4'he, 24'h12fff1, 4'he};
endfunction

`endif

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  localparam int num_retires = 250;
  localparam int cycle_limit = 20;
  localparam int reset_limit = 200;

  logic       clk;
  logic       nreset;
  logic       load_we;
  code_addr_t load_addr;
  word_t      load_data;
  logic       retire_valid;
  retire_t    retire;
  store_t     store;

  int value_errors = 0;
  int other_errors = 0;

  `include "cpu_model.svh"

  cpu UUT (
    .clk(clk), .nreset(nreset),
    .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
    .retire_valid(retire_valid), .retire(retire), .store(store)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_val(string name, word_t got, word_t exp);
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // program load under reset

  initial begin
    int i;
    nreset = 1'b0;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_program();
    m_pc = '0;
    m_flags = '0;
    for (i = 0; i < 64; i++) begin
      @(posedge clk);
      #2;
      load_we = 1'b1;
      load_addr = code_addr_t'(i);
      load_data = prog[i];
    end
    @(posedge clk);
    #2;
    load_we = 1'b0;
    // five more reset cycles once the program is in
    repeat (5) @(posedge clk);
    #2;
    nreset = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // compare against the model, sampled on the falling edge

  initial begin
    retire_t exp_ret;
    store_t  exp_st;
    int      n;
    int      cycles;
    int      stores_seen;
    logic    got;
    logic    timed_out;
    timed_out = 1'b0;
    cycles = 0;
    // the falling edge that first sees reset released is cycle 1
    do begin
      @(negedge clk);
      cycles++;
      assert (!retire_valid && !store.we) else begin
        $display("retire or store strobe active at t=%0t before the first retire", $time);
        other_errors++;
      end
    end while (!nreset && cycles < reset_limit);
    if (!nreset) begin
      $display("timeout: reset was never released");
      other_errors++;
      timed_out = 1'b1;
    end
    for (n = 0; n < num_retires && !timed_out; n++) begin
      model_step(exp_ret, exp_st);
      stores_seen = 0;
      cycles = (n == 0) ? 1 : 0;
      got = 1'b0;
      while (!got && cycles < cycle_limit) begin
        @(negedge clk);
        cycles++;
        if (store.we) begin
          stores_seen++;
          if (exp_st.we) begin
            check_val("store.addr", {28'd0, store.addr}, {28'd0, exp_st.addr});
            check_val("store.data", store.data, exp_st.data);
          end
        end
        got = retire_valid;
      end
      if (!got) begin
        $display("timeout: retire %0d did not arrive within %0d cycles", n, cycle_limit);
        other_errors++;
        timed_out = 1'b1;
      end else begin
        assert (cycles == 5) else begin
          $display("retire %0d came %0d cycles after the previous one instead of 5",
                   n, cycles);
          other_errors++;
        end
        assert (stores_seen == (exp_st.we ? 1 : 0)) else begin
          $display("instruction at pc %h gave %0d store strobes, expected %0d",
                   exp_ret.pc, stores_seen, exp_st.we);
          other_errors++;
        end
        check_val("retire.pc", retire.pc, exp_ret.pc);
        check_val("retire.executed", {31'd0, retire.executed}, {31'd0, exp_ret.executed});
        check_val("retire.reg_we", {31'd0, retire.reg_we}, {31'd0, exp_ret.reg_we});
        if (exp_ret.reg_we) begin
          check_val("retire.rd", {28'd0, retire.rd}, {28'd0, exp_ret.rd});
          check_val("retire.value", retire.value, exp_ret.value);
        end
        check_val("retire.flags", {28'd0, retire.flags}, {28'd0, exp_ret.flags});
      end
    end
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+sim
rtl/cpu_isa_pkg.sv
rtl/cpu_core_pkg.sv
rtl/code_mem.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/data_mem.sv
rtl/cpu_control.sv
rtl/cpu.sv
sim/tb_cpu.sv
